// ==== logic/csrPkg.sv ====
// CSR block shared definitions
`default_nettype none

package csrPkg;

    localparam int LED_COUNT = 4;

    typedef logic [11:0]          csrAddrT;
    typedef logic [31:0]          csrDataT;
    typedef logic [LED_COUNT-1:0] ledT;
    typedef logic [31:0]          timerCountT;

    // Modify code from the E stage
    typedef enum logic [2:0] {
        OP_NONE  = 3'd0,
        OP_WRITE = 3'd1,
        OP_SET   = 3'd2,
        OP_CLEAR = 3'd3
    } csrOpT;

    localparam ledT LED_RESET = ledT'(1);  // LED 0 lit after reset

    // Identity values
    localparam csrDataT ID_ISA    = 32'h4000_0100;  // RV32I
    localparam csrDataT ID_VENDOR = 32'h0000_0011;
    localparam csrDataT ID_ARCH   = 32'h0000_0022;
    localparam csrDataT ID_IMP    = 32'h0001_0003;
    localparam csrDataT ID_HART   = 32'h0000_0005;
    localparam csrDataT CLOCK_KHZ = 32'd25_000;     // 40 ns clock

    localparam csrAddrT ADDR_MISA      = 12'h301;
    localparam csrAddrT ADDR_MVENDORID = 12'hF11;
    localparam csrAddrT ADDR_MARCHID   = 12'hF12;
    localparam csrAddrT ADDR_MIMPID    = 12'hF13;
    localparam csrAddrT ADDR_MHARTID   = 12'hF14;
    localparam csrAddrT ADDR_KHZ       = 12'hFC0;

    // Counter aliases
    localparam csrAddrT ADDR_MCYCLE     = 12'hB00;
    localparam csrAddrT ADDR_CYCLE      = 12'hC00;
    localparam csrAddrT ADDR_TIME       = 12'hC01;
    localparam csrAddrT ADDR_MCYCLEH    = 12'hB80;
    localparam csrAddrT ADDR_CYCLEH     = 12'hC80;
    localparam csrAddrT ADDR_TIMEH      = 12'hC81;
    localparam csrAddrT ADDR_MINSTRET   = 12'hB02;
    localparam csrAddrT ADDR_INSTRET    = 12'hC02;
    localparam csrAddrT ADDR_MINSTRETH  = 12'hB82;
    localparam csrAddrT ADDR_INSTRETH   = 12'hC82;

    localparam csrAddrT ADDR_LEDS  = 12'hBC1;
    localparam csrAddrT ADDR_TIMER = 12'hBC2;

endpackage

`default_nettype wire

// ==== logic/csrIdent.sv ====
// Machine identity registers
`timescale 1ns/1ps
`default_nettype none

module csrIdent (
    input  wire            clk,
    input  csrPkg::csrAddrT addr,
    output logic           valid,
    output csrPkg::csrDataT rdata
);
    import csrPkg::*;

    logic hitIsa, hitVendor, hitArch, hitImp, hitHart, hitKhz;
    logic selIsa, selVendor, selArch, selImp, selHart, selKhz;
    csrDataT rdataQ;

    // D stage decode
    assign hitIsa    = (addr == ADDR_MISA);
    assign hitVendor = (addr == ADDR_MVENDORID);
    assign hitArch   = (addr == ADDR_MARCHID);
    assign hitImp    = (addr == ADDR_MIMPID);
    assign hitHart   = (addr == ADDR_MHARTID);
    assign hitKhz    = (addr == ADDR_KHZ);

    assign valid = hitIsa | hitVendor | hitArch | hitImp | hitHart | hitKhz;
    assign rdata = rdataQ;

    always_ff @(posedge clk) begin
        selIsa    <= hitIsa;
        selVendor <= hitVendor;
        selArch   <= hitArch;
        selImp    <= hitImp;
        selHart   <= hitHart;
        selKhz    <= hitKhz;

        // One-hot selects, so an OR picks the constant
        rdataQ <= (selIsa    ? ID_ISA    : '0)
                | (selVendor ? ID_VENDOR : '0)
                | (selArch   ? ID_ARCH   : '0)
                | (selImp    ? ID_IMP    : '0)
                | (selHart   ? ID_HART   : '0)
                | (selKhz    ? CLOCK_KHZ : '0);
    end

endmodule

`default_nettype wire

// ==== logic/csrCounters.sv ====
// Cycle and instret counters
`timescale 1ns/1ps
`default_nettype none

module csrCounters (
    input  wire            clk,
    input  wire            rstn,
    input  csrPkg::csrAddrT addr,
    input  wire            retired,
    output logic           valid,
    output csrPkg::csrDataT rdata
);
    import csrPkg::*;

    logic hitCycleLo, hitCycleHi, hitInstretLo, hitInstretHi;
    logic selCycleLo, selCycleHi, selInstretLo, selInstretHi;

    // Low halves carry one extra bit for the delayed carry
    logic [32:0] cycleLo;
    csrDataT     cycleHi;
    logic [32:0] instretLo;
    csrDataT     instretHi;
    csrDataT     rdataQ;

    assign hitCycleLo = (addr == ADDR_MCYCLE)
                      | (addr == ADDR_CYCLE)
                      | (addr == ADDR_TIME);     // Time shares the cycle counter
    assign hitCycleHi = (addr == ADDR_MCYCLEH)
                      | (addr == ADDR_CYCLEH)
                      | (addr == ADDR_TIMEH);
    assign hitInstretLo = (addr == ADDR_MINSTRET)
                        | (addr == ADDR_INSTRET);
    assign hitInstretHi = (addr == ADDR_MINSTRETH)
                        | (addr == ADDR_INSTRETH);

    assign valid = hitCycleLo | hitCycleHi | hitInstretLo | hitInstretHi;
    assign rdata = rdataQ;

    // Carry out of the low half lands in the high half one clock later
    always_ff @(posedge clk) begin
        if (!rstn) begin
            cycleLo   <= '0;
            cycleHi   <= '0;
            instretLo <= '0;
            instretHi <= '0;
        end else begin
            cycleLo   <= {1'b0, cycleLo[31:0]} + 33'd1;
            cycleHi   <= cycleHi + csrDataT'(cycleLo[32]);
            instretLo <= {1'b0, instretLo[31:0]} + {32'd0, retired};
            instretHi <= instretHi + csrDataT'(instretLo[32]);
        end
    end

    always_ff @(posedge clk) begin
        selCycleLo   <= hitCycleLo;
        selCycleHi   <= hitCycleHi;
        selInstretLo <= hitInstretLo;
        selInstretHi <= hitInstretHi;

        // E stage read
        rdataQ <= (selCycleLo   ? cycleLo[31:0]   : '0)
                | (selCycleHi   ? cycleHi         : '0)
                | (selInstretLo ? instretLo[31:0] : '0)
                | (selInstretHi ? instretHi       : '0);
    end

endmodule

`default_nettype wire

// ==== logic/csrLedPins.sv ====
// LED output register
`timescale 1ns/1ps
`default_nettype none

module csrLedPins (
    input  wire             clk,
    input  wire             rstn,
    input  csrPkg::csrAddrT addr,
    input  csrPkg::csrOpT   modify,
    input  csrPkg::csrDataT wdata,
    output logic            valid,
    output csrPkg::csrDataT rdata,
    output csrPkg::ledT     leds
);
    import csrPkg::*;

    logic    hitLeds;
    logic    selLeds;
    ledT     ledsQ;
    ledT     wLeds;
    csrDataT rdataQ;

    assign hitLeds = (addr == ADDR_LEDS);
    assign valid   = hitLeds;
    assign wLeds   = ledT'(wdata);  // Upper bits of wdata ignored
    assign leds    = ledsQ;
    assign rdata   = rdataQ;

    always_ff @(posedge clk) begin
        selLeds <= hitLeds;
        rdataQ  <= selLeds ? csrDataT'(ledsQ) : '0;  // Value before this write
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ledsQ <= LED_RESET;
        end else if (selLeds) begin
            case (modify)
                OP_WRITE: ledsQ <= wLeds;
                OP_SET:   ledsQ <= ledsQ | wLeds;
                OP_CLEAR: ledsQ <= ledsQ & ~wLeds;
                default:  ;                          // Plain read
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/csrTimer.sv ====
// Relative timer with interrupt
`timescale 1ns/1ps
`default_nettype none

module csrTimer (
    input  wire             clk,
    input  wire             rstn,
    input  csrPkg::csrAddrT addr,
    input  csrPkg::csrOpT   modify,
    input  csrPkg::csrDataT wdata,
    output logic            valid,
    output logic            irq
);
    import csrPkg::*;

    logic       hitTimer;
    logic       selTimer;
    timerCountT count;
    logic       armed;
    logic       irqQ;

    assign hitTimer = (addr == ADDR_TIMER);
    assign valid    = hitTimer;
    assign irq      = irqQ;

    always_ff @(posedge clk) begin
        selTimer <= hitTimer;
    end

    // Count runs down to zero and parks there
    always_ff @(posedge clk) begin
        if (!rstn) begin
            count <= '0;
            armed <= 1'b0;
            irqQ  <= 1'b0;
        end else begin
            irqQ <= armed && (count == '0);

            if (count != '0) begin
                count <= count - timerCountT'(1);
            end

            // A write from the E stage overrides the decrement
            if (selTimer) begin
                case (modify)
                    OP_WRITE: begin
                        count <= timerCountT'(wdata);
                        armed <= 1'b1;
                    end
                    OP_CLEAR: armed <= 1'b0;   // Any clear value disarms
                    OP_NONE,
                    OP_SET:   ;
                    default:  ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/csrBlock.sv ====
// CSR unit top level
`timescale 1ns/1ps
`default_nettype none

module csrBlock (
    input  wire             clk,
    input  wire             rstn,
    input  csrPkg::csrAddrT addr,
    input  csrPkg::csrOpT   modify,
    input  csrPkg::csrDataT wdata,
    output csrPkg::csrDataT rdata,
    output logic            valid,
    input  wire             retired,
    output csrPkg::ledT     leds,
    output logic            irqTimer
);
    import csrPkg::*;

    logic    identValid;
    csrDataT identRdata;
    logic    countersValid;
    csrDataT countersRdata;
    logic    ledsValid;
    csrDataT ledsRdata;
    logic    timerValid;

    // Unselected groups return zero, so OR works as the read mux
    assign valid = identValid | countersValid | ledsValid | timerValid;
    assign rdata = identRdata | countersRdata | ledsRdata;

    csrIdent identInst (
        .clk   (clk),
        .addr  (addr),
        .valid (identValid),
        .rdata (identRdata)
    );

    csrCounters countersInst (
        .clk     (clk),
        .rstn    (rstn),
        .addr    (addr),
        .retired (retired),
        .valid   (countersValid),
        .rdata   (countersRdata)
    );

    csrLedPins ledsInst (
        .clk    (clk),
        .rstn   (rstn),
        .addr   (addr),
        .modify (modify),
        .wdata  (wdata),
        .valid  (ledsValid),
        .rdata  (ledsRdata),
        .leds   (leds)
    );

    // Timer reads back as zero, so no read data here
    csrTimer timerInst (
        .clk    (clk),
        .rstn   (rstn),
        .addr   (addr),
        .modify (modify),
        .wdata  (wdata),
        .valid  (timerValid),
        .irq    (irqTimer)
    );

endmodule

`default_nettype wire

// ==== sim/clockGen.sv ====
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module clockGen (
    output logic clk,
    output logic rstn
);
    localparam int RESET_CYCLES = 5;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    // Release on a rising edge, like the rest of the stimulus
    initial begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rstn <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== sim/csrBlock_properties.sv ====
// CSR bus protocol assertions
`timescale 1ns/1ps
`default_nettype none

module csrBlockProperties (
    input wire             clk,
    input wire             rstn,
    input csrPkg::csrAddrT addr,
    input wire             valid,
    input csrPkg::csrDataT rdata,
    input csrPkg::ledT     leds,
    input wire             irqTimer
);
    import csrPkg::*;

    // Unselected groups all return zero
    rdataIdle: assert property (@(posedge clk) disable iff (!rstn)
        !$past(valid, 2) |-> rdata == '0)
        else $error("rdata nonzero without a valid address two cycles earlier");

    irqAfterReset: assert property (@(posedge clk) !rstn |=> !irqTimer)
        else $error("irqTimer high in the cycle after reset");

    // Write lands at the end of the E stage
    ledsWrite: assert property (@(posedge clk) disable iff (!rstn)
        $changed(leds) |-> $past(addr, 2) == ADDR_LEDS)
        else $error("leds changed without an LED access");

endmodule

bind csrBlock csrBlockProperties csrBlockPropsInst (
    .clk      (clk),
    .rstn     (rstn),
    .addr     (addr),
    .valid    (valid),
    .rdata    (rdata),
    .leds     (leds),
    .irqTimer (irqTimer)
);

`default_nettype wire

// ==== sim/csrBlockTb.sv ====
// CSR block testbench
`timescale 1ns/1ps
`default_nettype none

module csrBlockTb;
    import csrPkg::*;

    localparam csrAddrT IDLE_ADDR      = 12'h000;  // Not a CSR
    localparam int      TEST_CYCLES    = 300;      // Rough sum over all five tests
    localparam int      TIMEOUT_CYCLES = 10 * TEST_CYCLES;

    logic        clk;
    logic        rstn;
    csrAddrT     addr;
    csrOpT       modify;
    csrDataT     wdata;
    csrDataT     rdata;
    logic        valid;
    logic        retired;
    ledT         leds;
    logic        irqTimer;
    int          cycleCount = 0;
    int          lastStart;                        // Cycle of the last D stage
    int          checkCount = 0;
    int          errorCount = 0;
    logic [31:0] lcgState   = 32'he381_a15e;

    clockGen clockGenInst (.clk(clk), .rstn(rstn));

    csrBlock csrBlock_inst (
        .clk      (clk),
        .rstn     (rstn),
        .addr     (addr),
        .modify   (modify),
        .wdata    (wdata),
        .rdata    (rdata),
        .valid    (valid),
        .retired  (retired),
        .leds     (leds),
        .irqTimer (irqTimer)
    );

    // Halves swapped so the weak low bits end up on top
    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return {lcgState[15:0], lcgState[31:16]};
    endfunction

    function automatic logic isKeptAddr(input csrAddrT a);
        case (a)
            ADDR_MISA, ADDR_MVENDORID, ADDR_MARCHID, ADDR_MIMPID, ADDR_MHARTID,
            ADDR_KHZ, ADDR_MCYCLE, ADDR_CYCLE, ADDR_TIME, ADDR_MCYCLEH,
            ADDR_CYCLEH, ADDR_TIMEH, ADDR_MINSTRET, ADDR_INSTRET, ADDR_MINSTRETH,
            ADDR_INSTRETH, ADDR_LEDS, ADDR_TIMER: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // D stage, E stage, then rdata one cycle later
    task automatic csrAccess(input csrAddrT a, input csrOpT op, input csrDataT d,
                             output csrDataT rd, output logic v);
        @(posedge clk);
        lastStart = cycleCount;
        addr <= a;
        @(negedge clk);
        v = valid;                                 // Combinational decode
        @(posedge clk);
        addr   <= IDLE_ADDR;
        modify <= op;
        wdata  <= d;
        @(posedge clk);
        modify <= OP_NONE;
        wdata  <= '0;
        @(negedge clk);
        rd = rdata;
    endtask

    task automatic checkData(input csrDataT got, input csrDataT exp, input string what);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("ERR @%0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic checkLeds(input ledT got, input ledT exp, input string what);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("ERR @%0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic checkBit(input logic got, input logic exp, input string what);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("ERR @%0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic reportTest(input string name, input int errBefore);
        if (errorCount == errBefore) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: %0d errors", name, errorCount - errBefore);
        end
    endtask

    task automatic identityTest();
        csrAddrT addrs [6];
        csrDataT exps [6];
        csrAddrT unused;
        csrDataT rd;
        logic    v;
        int      errBefore;
        errBefore = errorCount;
        addrs = '{ADDR_MISA, ADDR_MVENDORID, ADDR_MARCHID, ADDR_MIMPID, ADDR_MHARTID, ADDR_KHZ};
        exps  = '{ID_ISA, ID_VENDOR, ID_ARCH, ID_IMP, ID_HART, CLOCK_KHZ};
        for (int i = 0; i < 6; i++) begin
            csrAccess(addrs[i], OP_NONE, '0, rd, v);
            checkBit(v, 1'b1, "identity valid");
            checkData(rd, exps[i], "identity read");
        end
        do begin
            unused = csrAddrT'(nextRand());
        end while (isKeptAddr(unused));
        csrAccess(unused, OP_NONE, '0, rd, v);
        checkBit(v, 1'b0, "unused address valid");
        checkData(rd, '0, "unused address read");
        reportTest("identity", errBefore);
    endtask

    task automatic counterTest();
        csrAddrT lowAliases [3];
        csrAddrT highAliases [5];
        csrDataT base;
        csrDataT rd;
        logic    v;
        int      baseStart;
        int      gap;
        int      errBefore;
        errBefore   = errorCount;
        lowAliases  = '{ADDR_MCYCLE, ADDR_CYCLE, ADDR_TIME};
        highAliases = '{ADDR_MCYCLEH, ADDR_CYCLEH, ADDR_TIMEH, ADDR_MINSTRETH, ADDR_INSTRETH};
        csrAccess(ADDR_MCYCLE, OP_NONE, '0, base, v);
        baseStart = lastStart;
        gap = int'(nextRand() % 32'd8) + 1;
        repeat (gap) @(posedge clk);
        // Every low alias advances by the distance between D stages
        foreach (lowAliases[i]) begin
            csrAccess(lowAliases[i], OP_NONE, '0, rd, v);
            checkBit(v, 1'b1, "cycle alias valid");
            checkData(rd, base + csrDataT'(lastStart - baseStart), "cycle alias read");
        end
        foreach (highAliases[i]) begin
            csrAccess(highAliases[i], OP_NONE, '0, rd, v);
            checkBit(v, 1'b1, "high half valid");
            checkData(rd, '0, "high half read");
        end
        reportTest("counters", errBefore);
    endtask

    task automatic instretTest();
        csrDataT rd;
        logic    v;
        logic    [31:0] r;
        int      k;
        int      errBefore;
        errBefore = errorCount;
        k = 0;
        csrAccess(ADDR_INSTRET, OP_NONE, '0, rd, v);
        checkData(rd, '0, "instret before pulses");
        for (int i = 0; i < 24; i++) begin
            @(posedge clk);
            r = nextRand();
            retired <= r[7];
            if (r[7]) k++;
        end
        @(posedge clk);
        retired <= 1'b0;
        csrAccess(ADDR_INSTRET, OP_NONE, '0, rd, v);
        checkBit(v, 1'b1, "instret valid");
        checkData(rd, csrDataT'(k), "instret count");
        csrAccess(ADDR_MINSTRET, OP_NONE, '0, rd, v);
        checkBit(v, 1'b1, "minstret valid");
        checkData(rd, csrDataT'(k), "minstret alias read");  // retired idle since
        reportTest("instret", errBefore);
    endtask

    task automatic ledTest();
        ledT     model;
        csrDataT d;
        csrDataT rd;
        csrOpT   op;
        logic    v;
        int      errBefore;
        errBefore = errorCount;
        model = LED_RESET;
        csrAccess(ADDR_LEDS, OP_NONE, '0, rd, v);
        checkData(rd, csrDataT'(LED_RESET), "first LED read");
        checkLeds(leds, LED_RESET, "leds after reset");
        for (int i = 0; i < 15; i++) begin
            case (nextRand() % 32'd3)
                32'd0:   op = OP_WRITE;
                32'd1:   op = OP_SET;
                default: op = OP_CLEAR;
            endcase
            d = nextRand();
            csrAccess(ADDR_LEDS, op, d, rd, v);
            checkBit(v, 1'b1, "LED valid");
            checkData(rd, csrDataT'(model), "LED read");  // Old value
            case (op)
                OP_WRITE: model = ledT'(d);
                OP_SET:   model = model | ledT'(d);
                default:  model = model & ~ledT'(d);
            endcase
            checkLeds(leds, model, "leds");
        end
        reportTest("leds", errBefore);
    endtask

    task automatic timerTest();
        csrDataT rd;
        logic    v;
        int      t;
        int      waits;
        int      errBefore;
        errBefore = errorCount;
        t = int'(nextRand() % 32'd24) + 2;
        csrAccess(ADDR_TIMER, OP_WRITE, csrDataT'(t), rd, v);
        checkBit(v, 1'b1, "timer valid");
        checkData(rd, '0, "timer read");
        waits = 0;
        while (irqTimer !== 1'b1 && waits < t + 10) begin
            @(negedge clk);
            waits++;
        end
        checkData(csrDataT'(waits), csrDataT'(t + 1), "cycles to irqTimer");
        repeat (3) begin
            @(negedge clk);
            checkBit(irqTimer, 1'b1, "irqTimer held");
        end
        csrAccess(ADDR_TIMER, OP_CLEAR, '0, rd, v);
        checkBit(irqTimer, 1'b1, "irqTimer at clear");
        @(negedge clk);
        checkBit(irqTimer, 1'b0, "irqTimer after clear");
        // Clear well before expiry
        t = int'(nextRand() % 32'd10) + 20;
        csrAccess(ADDR_TIMER, OP_WRITE, csrDataT'(t), rd, v);
        repeat (5) @(posedge clk);
        csrAccess(ADDR_TIMER, OP_CLEAR, '0, rd, v);
        repeat (t + 5) begin
            @(negedge clk);
            checkBit(irqTimer, 1'b0, "irqTimer after early clear");
        end
        reportTest("timer", errBefore);
    endtask

    initial begin
        while (cycleCount < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycleCount <= cycleCount + 1;
        end
        $display("Timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        addr    = IDLE_ADDR;
        modify  = OP_NONE;
        wdata   = '0;
        retired = 1'b0;
        wait (rstn === 1'b1);
        @(negedge clk);
        checkBit(irqTimer, 1'b0, "irqTimer after reset");
        identityTest();
        counterTest();
        instretTest();
        ledTest();
        timerTest();
        $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== csrBlock.f ====
logic/csrPkg.sv
logic/csrIdent.sv
logic/csrCounters.sv
logic/csrLedPins.sv
logic/csrTimer.sv
logic/csrBlock.sv
sim/clockGen.sv
sim/csrBlock_properties.sv
sim/csrBlockTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the csrBlock testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f csrBlock.f --top-module csrBlockTb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

output=$(./obj_dir/VcsrBlockTb)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1
